// ==== Makefile ====
# Verilator simulation of the L1 data cache data stage

SIM_LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f files.f --top-module dcache_tb -o dcache_sim
	./obj_dir/dcache_sim > $(SIM_LOG) 2>&1 || true
	@cat $(SIM_LOG)
	@grep -q "RESULT: PASS" $(SIM_LOG)

clean:
	rm -rf obj_dir $(SIM_LOG)

// ==== bench/clock_gen.sv ====
// Testbench clock source with a power-on reset held for a fixed number of cycles
`timescale 1ns/10ps

module clock_gen
#(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 10
)
(
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Reset drops on a rising edge once the cycle count is reached
    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== bench/dcache_tb.sv ====
// Table-driven testbench for the L1 data cache data stage with a byte-level line model
`timescale 1ns/10ps
`include "l1d_settings.svh"

module dcache_tb
    import mem_access_pkg::*;
    import l1d_cache_pkg::*;
();

    localparam int RESP_TIMEOUT  = 20;
    localparam int RESET_TIMEOUT = 50;

    typedef enum
    {
        STEP_REQ,
        STEP_FILL,
        STEP_CREDIT,
        STEP_COLLIDE
    } step_kind_t;

    // One table row, the way is used by fills and collisions only
    typedef struct
    {
        step_kind_t   kind;
        mem_op_t      op;
        logic [31:0]  addr;
        logic [31:0]  value;
        int           way;
        resp_status_t status;
        logic         from_model;
        logic [31:0]  data;
    } step_t;

    logic          clk;
    logic          reset;
    logic          req_valid;
    mem_request_t  req;
    logic          fill_valid;
    l1d_fill_t     fill;
    logic          miss_valid;
    l1d_miss_t     miss;
    logic          miss_credit;
    logic          resp_valid;
    mem_response_t resp;

    step_t         steps[$];
    // Expected memory contents, one byte per address of every filled line
    logic [7:0]    model_bytes [logic [31:0]];

    clock_gen u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    dcache_data_stage uut (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req         (req),
        .fill_valid  (fill_valid),
        .fill        (fill),
        .miss_valid  (miss_valid),
        .miss        (miss),
        .miss_credit (miss_credit),
        .resp_valid  (resp_valid),
        .resp        (resp)
    );

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
        input logic [63:0] expected);
        if (actual !== expected)
        begin
            $display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, actual, expected);
            stop_with_failure("Value mismatch");
        end
    endtask

    task automatic add_step(input step_kind_t kind, input mem_op_t op, input logic [31:0] addr,
        input logic [31:0] value, input int way, input resp_status_t status,
        input logic from_model, input logic [31:0] data);
        step_t s;
        s.kind = kind;
        s.op = op;
        s.addr = addr;
        s.value = value;
        s.way = way;
        s.status = status;
        s.from_model = from_model;
        s.data = data;
        steps.push_back(s);
    endtask

    // Big-endian view: the lowest address holds the most significant byte
    function automatic logic [31:0] model_load(input mem_op_t op, input logic [31:0] a);
        logic [7:0] b0;
        logic [7:0] b1;
        b0 = model_bytes[a];
        b1 = (op == OP_LH || op == OP_LHS || op == OP_LW) ? model_bytes[a + 1] : 8'h00;
        case (op)
            OP_LB: return {24'd0, b0};
            OP_LBS: return {{24{b0[7]}}, b0};
            OP_LH: return {16'd0, b0, b1};
            OP_LHS: return {{16{b0[7]}}, b0, b1};
            default: return {b0, b1, model_bytes[a + 2], model_bytes[a + 3]};
        endcase
    endfunction

    task automatic model_store(input mem_op_t op, input logic [31:0] a, input logic [31:0] v);
        case (op)
            OP_SB:
                model_bytes[a] = v[7:0];
            OP_SH:
            begin
                model_bytes[a] = v[15:8];
                model_bytes[a + 1] = v[7:0];
            end
            default:
            begin
                model_bytes[a] = v[31:24];
                model_bytes[a + 1] = v[23:16];
                model_bytes[a + 2] = v[15:8];
                model_bytes[a + 3] = v[7:0];
            end
        endcase
    endtask

    // Random line for the set and tag of addr, mirrored into the model
    function automatic l1d_fill_t make_fill(input logic [31:0] addr, input int way);
        l1d_fill_t   f;
        l1d_addr_t   a;
        logic [31:0] base;
        logic [7:0]  b;
        a = addr;
        base = {addr[31:`L1D_OFFSET_BITS], {`L1D_OFFSET_BITS{1'b0}}};
        f.way = l1d_way_idx_t'(way);
        f.set_idx = a.set_idx;
        f.tag = a.tag;
        for (int k = 0; k < `L1D_LINE_BYTES; k++)
        begin
            b = 8'($urandom);
            f.data[8*k +: 8] = b;
            model_bytes[base + k] = b;
        end
        return f;
    endfunction

    task automatic apply_fill(input step_t s);
        l1d_fill_t f;
        f = make_fill(s.addr, s.way);
        @(posedge clk);
        fill_valid <= 1'b1;
        fill <= f;
        @(posedge clk);
        fill_valid <= 1'b0;
    endtask

    task automatic return_credit();
        @(posedge clk);
        miss_credit <= 1'b1;
        @(posedge clk);
        miss_credit <= 1'b0;
    endtask

    task automatic run_request(input step_t s, input logic with_fill);
        l1d_fill_t   f;
        int          cycles;
        logic        is_store;
        logic [31:0] expected_data;
        is_store = s.op == OP_SB || s.op == OP_SH || s.op == OP_SW;
        f = '0;
        if (with_fill)
            f = make_fill(s.addr, s.way);
        @(posedge clk);
        req_valid <= 1'b1;
        req.op <= s.op;
        req.addr <= s.addr;
        req.store_value <= s.value;
        if (with_fill)
        begin
            fill_valid <= 1'b1;
            fill <= f;
        end
        @(posedge clk);
        req_valid <= 1'b0;
        fill_valid <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (!resp_valid)
        begin
            if (cycles == RESP_TIMEOUT)
                stop_with_failure("Timed out waiting for resp_valid");
            @(negedge clk);
            cycles++;
        end
        check_value("response latency", cycles, 0);
        check_value("resp.status", resp.status, s.status);
        check_value("resp.is_store", resp.is_store, is_store);
        check_value("miss_valid", miss_valid, s.status == RESP_MISS);
        if (s.status == RESP_MISS)
        begin
            check_value("miss.line_addr", miss.line_addr, s.addr >> `L1D_OFFSET_BITS);
            check_value("miss.is_store", miss.is_store, is_store);
        end
        if (s.status == RESP_HIT && !is_store)
        begin
            expected_data = s.from_model ? model_load(s.op, s.addr) : s.data;
            check_value("resp.load_data", resp.load_data, expected_data);
        end
        if (s.status == RESP_HIT && is_store)
            model_store(s.op, s.addr, s.value);
    endtask

    task automatic build_table();
        // Cold miss, then the fill of line A in way 0
        add_step(STEP_REQ, OP_LW, 32'h1234_5040, 32'h0, 0, RESP_MISS, 1'b0, 32'h0);
        add_step(STEP_CREDIT, OP_LW, 32'h0, 32'h0, 0, RESP_HIT, 1'b0, 32'h0);
        add_step(STEP_FILL, OP_LW, 32'h1234_5040, 32'h0, 0, RESP_HIT, 1'b0, 32'h0);
        add_step(STEP_REQ, OP_LW, 32'h1234_5044, 32'h0, 0, RESP_HIT, 1'b1, 32'h0);
        add_step(STEP_REQ, OP_LH, 32'h1234_5046, 32'h0, 0, RESP_HIT, 1'b1, 32'h0);
        add_step(STEP_REQ, OP_LHS, 32'h1234_5048, 32'h0, 0, RESP_HIT, 1'b1, 32'h0);
        add_step(STEP_REQ, OP_LB, 32'h1234_504B, 32'h0, 0, RESP_HIT, 1'b1, 32'h0);
        add_step(STEP_REQ, OP_LBS, 32'h1234_504D, 32'h0, 0, RESP_HIT, 1'b1, 32'h0);
        // Store hits, checked through the model and through fixed values
        add_step(STEP_REQ, OP_SB, 32'h1234_5050, 32'hA5, 0, RESP_HIT, 1'b0, 32'h0);
        add_step(STEP_REQ, OP_SH, 32'h1234_5052, 32'h8001, 0, RESP_HIT, 1'b0, 32'h0);
        add_step(STEP_REQ, OP_SW, 32'h1234_5054, 32'hDEAD_BEEF, 0, RESP_HIT, 1'b0, 32'h0);
        add_step(STEP_REQ, OP_LW, 32'h1234_5050, 32'h0, 0, RESP_HIT, 1'b1, 32'h0);
        add_step(STEP_REQ, OP_LW, 32'h1234_5054, 32'h0, 0, RESP_HIT, 1'b1, 32'h0);
        add_step(STEP_REQ, OP_LBS, 32'h1234_5050, 32'h0, 0, RESP_HIT, 1'b0, 32'hFFFF_FFA5);
        add_step(STEP_REQ, OP_LB, 32'h1234_5050, 32'h0, 0, RESP_HIT, 1'b0, 32'h0000_00A5);
        add_step(STEP_REQ, OP_LHS, 32'h1234_5052, 32'h0, 0, RESP_HIT, 1'b0, 32'hFFFF_8001);
        add_step(STEP_REQ, OP_LH, 32'h1234_5052, 32'h0, 0, RESP_HIT, 1'b0, 32'h0000_8001);
        // Unaligned accesses fault and leave the line alone
        add_step(STEP_REQ, OP_LH, 32'h1234_5041, 32'h0, 0, RESP_FAULT, 1'b0, 32'h0);
        add_step(STEP_REQ, OP_SW, 32'h1234_5042, 32'h1122_3344, 0, RESP_FAULT, 1'b0, 32'h0);
        add_step(STEP_REQ, OP_SH, 32'h1234_5043, 32'h5566, 0, RESP_FAULT, 1'b0, 32'h0);
        add_step(STEP_REQ, OP_LW, 32'h5000_0001, 32'h0, 0, RESP_FAULT, 1'b0, 32'h0);
        add_step(STEP_REQ, OP_LW, 32'h1234_5040, 32'h0, 0, RESP_HIT, 1'b1, 32'h0);
        // Exhaust all four credits, then retry until one comes back
        add_step(STEP_REQ, OP_LW, 32'h6000_0000, 32'h0, 0, RESP_MISS, 1'b0, 32'h0);
        add_step(STEP_REQ, OP_LW, 32'h6000_1000, 32'h0, 0, RESP_MISS, 1'b0, 32'h0);
        add_step(STEP_REQ, OP_SW, 32'h6000_2000, 32'h0, 0, RESP_MISS, 1'b0, 32'h0);
        add_step(STEP_REQ, OP_LW, 32'h6000_3000, 32'h0, 0, RESP_MISS, 1'b0, 32'h0);
        add_step(STEP_REQ, OP_LW, 32'h6000_4000, 32'h0, 0, RESP_RETRY, 1'b0, 32'h0);
        add_step(STEP_CREDIT, OP_LW, 32'h0, 32'h0, 0, RESP_HIT, 1'b0, 32'h0);
        add_step(STEP_REQ, OP_LW, 32'h6000_4000, 32'h0, 0, RESP_MISS, 1'b0, 32'h0);
        for (int i = 0; i < `L1D_MISS_CREDITS; i++)
            add_step(STEP_CREDIT, OP_LW, 32'h0, 32'h0, 0, RESP_HIT, 1'b0, 32'h0);
        // Requests that meet a fill to their own set
        add_step(STEP_COLLIDE, OP_LW, 32'h0007_70C0, 32'h0, 1, RESP_RETRY, 1'b0, 32'h0);
        add_step(STEP_REQ, OP_LW, 32'h0007_70C4, 32'h0, 0, RESP_HIT, 1'b1, 32'h0);
        add_step(STEP_COLLIDE, OP_SW, 32'h1234_5054, 32'h0102_0304, 0, RESP_RETRY, 1'b0, 32'h0);
        add_step(STEP_REQ, OP_LW, 32'h1234_5054, 32'h0, 0, RESP_HIT, 1'b1, 32'h0);
    endtask

    initial
    begin
        int cycles;
        req_valid = 1'b0;
        req = '0;
        fill_valid = 1'b0;
        fill = '0;
        miss_credit = 1'b0;
        void'($urandom(56));
        build_table();
        cycles = 0;
        @(negedge clk);
        while (reset)
        begin
            if (cycles == RESET_TIMEOUT)
                stop_with_failure("Reset was never released");
            @(negedge clk);
            cycles++;
        end
        foreach (steps[i])
        begin
            case (steps[i].kind)
                STEP_REQ: run_request(steps[i], 1'b0);
                STEP_COLLIDE: run_request(steps[i], 1'b1);
                STEP_FILL: apply_fill(steps[i]);
                default: return_credit();
            endcase
        end
        @(posedge clk);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== design/access_decode.sv ====
// Request decode: access class, alignment check and big-endian store byte placement
`timescale 1ns/10ps
`include "l1d_settings.svh"

module access_decode
    import mem_access_pkg::*;
    import l1d_cache_pkg::*;
(
    input  logic            req_valid,
    input  mem_request_t    req,
    output logic            acc_valid,
    output decoded_access_t acc
);

    localparam int LINE_BYTES = `L1D_LINE_BYTES;

    l1d_addr_t               req_addr;
    logic [1:0]              byte_pos;
    logic [3:0]              word_lane;
    logic [3:0]              lane_bytes;
    logic                    is_store;
    logic                    unaligned;
    logic [LINE_BYTES-1:0]   raw_mask;
    cache_line_t             store_line;

    assign req_addr  = req.addr;
    assign byte_pos  = req_addr.offset[1:0];
    assign word_lane = req_addr.offset[`L1D_OFFSET_BITS-1:2];

    // Halves need an even address, words a multiple of four
    always_comb
    begin
        is_store = 1'b0;
        unaligned = 1'b0;
        case (req.op)
            OP_LH, OP_LHS:
                unaligned = byte_pos[0];
            OP_LW:
                unaligned = |byte_pos;
            OP_SB:
                is_store = 1'b1;
            OP_SH:
            begin
                is_store = 1'b1;
                unaligned = byte_pos[0];
            end
            OP_SW:
            begin
                is_store = 1'b1;
                unaligned = |byte_pos;
            end
            default:
                is_store = 1'b0;
        endcase
    end

    // Bytes touched within the word, and the value copied to every lane
    // with the most significant byte at the lowest address
    always_comb
    begin
        case (req.op)
            OP_LB, OP_LBS, OP_SB:
            begin
                lane_bytes = 4'b0001 << byte_pos;
                store_line = {LINE_BYTES{req.store_value[7:0]}};
            end
            OP_LH, OP_LHS, OP_SH:
            begin
                lane_bytes = byte_pos[1] ? 4'b1100 : 4'b0011;
                store_line = {(LINE_BYTES / 2){req.store_value[7:0], req.store_value[15:8]}};
            end
            default:
            begin
                lane_bytes = 4'b1111;
                store_line = {(LINE_BYTES / 4){req.store_value[7:0], req.store_value[15:8],
                    req.store_value[23:16], req.store_value[31:24]}};
            end
        endcase
    end

    assign raw_mask = LINE_BYTES'(lane_bytes) << {word_lane, 2'b00};

    assign acc_valid = req_valid;

    always_comb
    begin
        acc.addr       = req_addr;
        acc.is_load    = !is_store;
        acc.is_store   = is_store;
        acc.op         = req.op;
        acc.byte_mask  = (is_store && !unaligned) ? raw_mask : '0;
        acc.store_line = store_line;
        acc.unaligned  = unaligned;
    end

    // An aligned store enables exactly its own bytes from the addressed one on,
    // loads and faulting accesses carry no write enables downstream
    always_comb
    begin
        if (req_valid && is_store && !unaligned)
            assert (acc.byte_mask == LINE_BYTES'((req.op == OP_SB) ? 4'b0001 :
                (req.op == OP_SH) ? 4'b0011 : 4'b1111) << req.addr[`L1D_OFFSET_BITS-1:0])
                else $error("Byte mask does not match the stored bytes");
        else if (req_valid)
            assert (acc.byte_mask == '0)
                else $error("Byte mask set for a load or unaligned access");
    end

endmodule

// ==== design/dcache_data_stage.sv ====
// L1 data cache data stage: request decode, tag and data lookup, response and miss issue
`timescale 1ns/10ps

module dcache_data_stage
    import mem_access_pkg::*;
    import l1d_cache_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          req_valid,
    input  mem_request_t  req,
    input  logic          fill_valid,
    input  l1d_fill_t     fill,
    output logic          miss_valid,
    output l1d_miss_t     miss,
    input  logic          miss_credit,
    output logic          resp_valid,
    output mem_response_t resp
);

    logic            acc_valid;
    decoded_access_t acc;
    logic            look_valid;
    logic            look_hit;
    logic            look_retry;
    cache_line_t     look_line;
    decoded_access_t look_acc;

    access_decode u_access_decode (
        .req_valid (req_valid),
        .req       (req),
        .acc_valid (acc_valid),
        .acc       (acc)
    );

    l1d_tag_data_array u_tag_data_array (
        .clk        (clk),
        .reset      (reset),
        .acc_valid  (acc_valid),
        .acc        (acc),
        .fill_valid (fill_valid),
        .fill       (fill),
        .look_valid (look_valid),
        .look_hit   (look_hit),
        .look_retry (look_retry),
        .look_line  (look_line),
        .look_acc   (look_acc)
    );

    load_response_stage u_load_response_stage (
        .clk         (clk),
        .reset       (reset),
        .look_valid  (look_valid),
        .look_hit    (look_hit),
        .look_retry  (look_retry),
        .look_line   (look_line),
        .look_acc    (look_acc),
        .miss_credit (miss_credit),
        .miss_valid  (miss_valid),
        .miss        (miss),
        .resp_valid  (resp_valid),
        .resp        (resp)
    );

endmodule

// ==== design/l1d_cache_pkg.sv ====
// Types for L1 data cache geometry, line fills, miss requests and decoded accesses
`include "l1d_settings.svh"

package l1d_cache_pkg;

    import mem_access_pkg::*;

    typedef logic [$clog2(`L1D_WAYS)-1:0] l1d_way_idx_t;
    typedef logic [`L1D_SET_BITS-1:0] l1d_set_idx_t;

    // Line byte k sits at bits 8k+7:8k
    typedef logic [`L1D_LINE_BYTES*8-1:0] cache_line_t;

    typedef struct packed
    {
        logic [`L1D_TAG_BITS-1:0]    tag;
        l1d_set_idx_t                set_idx;
        logic [`L1D_OFFSET_BITS-1:0] offset;
    } l1d_addr_t;

    // Line fill from the L2 side, the way is chosen there
    typedef struct packed
    {
        l1d_way_idx_t             way;
        l1d_set_idx_t             set_idx;
        logic [`L1D_TAG_BITS-1:0] tag;
        cache_line_t              data;
    } l1d_fill_t;

    // Line address is the request address without its offset bits
    typedef struct packed
    {
        logic [`L1D_TAG_BITS+`L1D_SET_BITS-1:0] line_addr;
        logic                                   is_store;
    } l1d_miss_t;

    typedef struct packed
    {
        l1d_addr_t                  addr;
        logic                       is_load;
        logic                       is_store;
        mem_op_t                    op;
        logic [`L1D_LINE_BYTES-1:0] byte_mask;
        cache_line_t                store_line;
        logic                       unaligned;
    } decoded_access_t;

endpackage

// ==== design/l1d_tag_data_array.sv ====
// Tag compare, valid bits, line storage with store merge and L2 fill writes
`timescale 1ns/10ps
`include "l1d_settings.svh"

module l1d_tag_data_array
    import l1d_cache_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            acc_valid,
    input  decoded_access_t acc,
    input  logic            fill_valid,
    input  l1d_fill_t       fill,
    output logic            look_valid,
    output logic            look_hit,
    output logic            look_retry,
    output cache_line_t     look_line,
    output decoded_access_t look_acc
);

    localparam int LINE_BYTES = `L1D_LINE_BYTES;

    logic [`L1D_TAG_BITS-1:0] tag_mem [`L1D_WAYS][`L1D_SETS];
    logic [`L1D_WAYS-1:0]     valid_mem [`L1D_SETS];
    cache_line_t              data_mem [`L1D_WAYS][`L1D_SETS];

    l1d_set_idx_t             set_idx;
    logic [`L1D_WAYS-1:0]     hit_oh;
    l1d_way_idx_t             hit_way;
    logic                     near_miss;
    logic                     hit;
    logic                     store_en;

    assign set_idx = acc.addr.set_idx;

    // Compare all ways of the set in the request cycle
    always_comb
    begin
        for (int w = 0; w < `L1D_WAYS; w++)
            hit_oh[w] = valid_mem[set_idx][w] && tag_mem[w][set_idx] == acc.addr.tag;
    end

    always_comb
    begin
        hit_way = '0;
        for (int w = 0; w < `L1D_WAYS; w++)
        begin
            if (hit_oh[w])
                hit_way = hit_way | l1d_way_idx_t'(w);
        end
    end

    // A fill landing in the same set this cycle may replace the line, so retry
    assign near_miss = acc_valid && fill_valid && fill.set_idx == set_idx;
    assign hit = acc_valid && |hit_oh && !acc.unaligned && !near_miss;
    assign store_en = hit && acc.is_store;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            for (int s = 0; s < `L1D_SETS; s++)
                valid_mem[s] <= '0;
        end
        else if (fill_valid)
            valid_mem[fill.set_idx][fill.way] <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (fill_valid)
            tag_mem[fill.way][fill.set_idx] <= fill.tag;
    end

    // Fill writes a whole line, a store hit only its masked bytes
    always_ff @(posedge clk)
    begin
        if (fill_valid)
            data_mem[fill.way][fill.set_idx] <= fill.data;
        if (store_en)
        begin
            for (int k = 0; k < LINE_BYTES; k++)
            begin
                if (acc.byte_mask[k])
                    data_mem[hit_way][set_idx][8*k +: 8] <= acc.store_line[8*k +: 8];
            end
        end
    end

    // Registered read of the hit line
    always_ff @(posedge clk)
    begin
        look_line <= data_mem[hit_way][set_idx];
        look_acc <= acc;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            look_valid <= 1'b0;
            look_hit <= 1'b0;
            look_retry <= 1'b0;
        end
        else
        begin
            look_valid <= acc_valid;
            look_hit <= hit;
            look_retry <= near_miss;
        end
    end

    // Fills pick the way, so a line must never end up in two ways of a set
    assert property (@(posedge clk) disable iff (reset) acc_valid |-> $onehot0(hit_oh))
        else $error("Line present in more than one way");

endmodule

// ==== design/load_response_stage.sv ====
// Response stage: status, big-endian load data extraction and credited miss requests
`timescale 1ns/10ps
`include "l1d_settings.svh"

module load_response_stage
    import mem_access_pkg::*;
    import l1d_cache_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            look_valid,
    input  logic            look_hit,
    input  logic            look_retry,
    input  cache_line_t     look_line,
    input  decoded_access_t look_acc,
    input  logic            miss_credit,
    output logic            miss_valid,
    output l1d_miss_t       miss,
    output logic            resp_valid,
    output mem_response_t   resp
);

    localparam int CREDIT_W = $clog2(`L1D_MISS_CREDITS + 1);

    logic [CREDIT_W-1:0] credit_count;
    logic [8:0]          word_base;
    logic [1:0]          byte_pos;
    logic [31:0]         line_word;
    logic [7:0]          sel_byte;
    logic [15:0]         sel_half;
    logic [31:0]         load_value;
    resp_status_t        status;

    // Fault wins, then retry from a fill collision, then hit, then miss
    // when a credit is left
    always_comb
    begin
        if (look_acc.unaligned)
            status = RESP_FAULT;
        else if (look_retry)
            status = RESP_RETRY;
        else if (look_hit)
            status = RESP_HIT;
        else if (credit_count == '0)
            status = RESP_RETRY;
        else
            status = RESP_MISS;
    end

    // Bit position of the addressed word in the line
    assign word_base = {look_acc.addr.offset[`L1D_OFFSET_BITS-1:2], 5'b00000};
    assign byte_pos = look_acc.addr.offset[1:0];

    // Lowest addressed byte becomes the most significant
    assign line_word = {look_line[word_base +: 8], look_line[word_base + 9'd8 +: 8],
        look_line[word_base + 9'd16 +: 8], look_line[word_base + 9'd24 +: 8]};

    always_comb
    begin
        case (byte_pos)
            2'd0: sel_byte = line_word[31:24];
            2'd1: sel_byte = line_word[23:16];
            2'd2: sel_byte = line_word[15:8];
            default: sel_byte = line_word[7:0];
        endcase
    end

    assign sel_half = byte_pos[1] ? line_word[15:0] : line_word[31:16];

    always_comb
    begin
        case (look_acc.op)
            OP_LB: load_value = {24'd0, sel_byte};
            OP_LBS: load_value = {{24{sel_byte[7]}}, sel_byte};
            OP_LH: load_value = {16'd0, sel_half};
            OP_LHS: load_value = {{16{sel_half[15]}}, sel_half};
            OP_LW: load_value = line_word;
            default: load_value = '0;
        endcase
    end

    assign resp_valid = look_valid;

    always_comb
    begin
        resp.status = status;
        resp.load_data = (status == RESP_HIT && look_acc.is_load) ? load_value : '0;
        resp.is_store = look_acc.is_store;
    end

    // Miss request leaves with the miss response
    assign miss_valid = look_valid && status == RESP_MISS;
    assign miss.line_addr = {look_acc.addr.tag, look_acc.addr.set_idx};
    assign miss.is_store = look_acc.is_store;

    // Returned credit is usable from the next cycle
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            credit_count <= CREDIT_W'(`L1D_MISS_CREDITS);
        else
            credit_count <= credit_count + CREDIT_W'(miss_credit) - CREDIT_W'(miss_valid);
    end

    // Too many returned credits, or a miss sent with none left, drives the count
    // past the limit
    assert property (@(posedge clk) disable iff (reset)
        credit_count <= CREDIT_W'(`L1D_MISS_CREDITS))
        else $error("Miss credit count out of range");

endmodule

// ==== design/mem_access_pkg.sv ====
// Types for pipeline memory requests and the responses returned to the requester
package mem_access_pkg;

    // Access opcodes, loads first
    typedef enum logic [2:0]
    {
        OP_LB,
        OP_LBS,
        OP_LH,
        OP_LHS,
        OP_LW,
        OP_SB,
        OP_SH,
        OP_SW
    } mem_op_t;

    // One request per cycle from the load/store pipeline
    typedef struct packed
    {
        mem_op_t     op;
        logic [31:0] addr;
        logic [31:0] store_value;
    } mem_request_t;

    typedef enum logic [1:0]
    {
        RESP_HIT,
        RESP_MISS,
        RESP_RETRY,
        RESP_FAULT
    } resp_status_t;

    // Load data is only meaningful for a load hit
    typedef struct packed
    {
        resp_status_t status;
        logic [31:0]  load_data;
        logic         is_store;
    } mem_response_t;

endpackage

// ==== files.f ====
+incdir+include
design/mem_access_pkg.sv
design/l1d_cache_pkg.sv
design/access_decode.sv
design/l1d_tag_data_array.sv
design/load_response_stage.sv
design/dcache_data_stage.sv
bench/clock_gen.sv
bench/dcache_tb.sv

// ==== include/l1d_settings.svh ====
// L1 data cache geometry and miss credit settings
`ifndef L1D_SETTINGS_SVH
`define L1D_SETTINGS_SVH

// Cache organization
`define L1D_WAYS 4
`define L1D_SETS 64
`define L1D_LINE_BYTES 64

// Split of a 32-bit address into tag, set index and line offset
`define L1D_OFFSET_BITS 6
`define L1D_SET_BITS 6
`define L1D_TAG_BITS 20

// Miss requests that may be outstanding toward L2
`define L1D_MISS_CREDITS 4

`endif
